//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam logic [31:0] sram_base = 32'h8000_0000;
    localparam int unsigned sram_words = 256;
    localparam logic [31:0] clint_base = 32'h0200_0000;
    localparam logic [31:0] clint_end = 32'h0200_ffff;

    typedef enum logic [1:0] {
        size_none = 2'b00,
        size_byte = 2'b01,
        size_half = 2'b10,
        size_word = 2'b11
    } mem_size_e;

    typedef enum logic [1:0] {
        resp_okay = 2'b00,
        resp_decerr = 2'b11 // axi decerr code
    } resp_e;

    typedef enum logic [2:0] {
        st_idle,
        st_ar,
        st_r,
        st_aw,
        st_w,
        st_b
    } lsu_state_e;

    // aw channel uses the same layout
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0] size; // axi size code
    } ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0] strb;
    } w_t;

    typedef struct packed {
        logic [31:0] data;
        resp_e resp;
    } r_t;

    typedef struct packed {
        resp_e resp;
    } b_t;

endpackage

`default_nettype wire

//--- design/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic wen,
    input wire logic ren,
    input wire logic sign,
    input mem_pkg::mem_size_e size,
    input wire logic [31:0] addr,
    input wire logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic done,
    output logic err,
    output mem_pkg::ar_t ar,
    output logic ar_valid,
    input wire logic ar_ready,
    input mem_pkg::r_t r,
    input wire logic r_valid,
    output mem_pkg::ar_t aw,
    output logic aw_valid,
    input wire logic aw_ready,
    output mem_pkg::w_t w,
    output logic w_valid,
    input wire logic w_ready,
    input mem_pkg::b_t b,
    input wire logic b_valid
);

    mem_pkg::lsu_state_e state;
    logic [2:0] axi_size;
    logic [3:0] strb;
    logic [31:0] shifted;
    logic [31:0] load_ext;
    logic done_q;
    logic err_q;
    logic [31:0] rdata_q;

    always_comb begin
        case (size)
            mem_pkg::size_half: axi_size = 3'b001;
            mem_pkg::size_word: axi_size = 3'b010;
            default: axi_size = 3'b000;
        endcase
    end

    always_comb begin
        case (size)
            mem_pkg::size_byte: strb = 4'b0001 << addr[1:0];
            mem_pkg::size_half: strb = addr[1] ? 4'b1100 : 4'b0011;
            mem_pkg::size_word: strb = 4'b1111;
            default: strb = 4'b0000;
        endcase
    end

    assign ar = '{addr: addr, size: axi_size};
    assign aw = '{addr: addr, size: axi_size};
    assign w = '{data: wdata << {addr[1:0], 3'b000}, strb: strb}; // move to byte lane

    assign ar_valid = (state == mem_pkg::st_ar);
    assign aw_valid = (state == mem_pkg::st_aw);
    assign w_valid = (state == mem_pkg::st_w); // one cycle after aw beat

    always_comb begin
        shifted = r.data >> {addr[1:0], 3'b000};
        case (size)
            mem_pkg::size_byte: load_ext = {{24{sign & shifted[7]}}, shifted[7:0]};
            mem_pkg::size_half: load_ext = {{16{sign & shifted[15]}}, shifted[15:0]};
            mem_pkg::size_word: load_ext = shifted;
            default: load_ext = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mem_pkg::st_idle;
            done_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            err_q <= 1'b0;
            case (state)
                mem_pkg::st_idle: begin
                    if (start && ren) begin
                        state <= mem_pkg::st_ar;
                    end else if (start && wen) begin
                        state <= mem_pkg::st_aw;
                    end
                end
                mem_pkg::st_ar: if (ar_ready) state <= mem_pkg::st_r;
                mem_pkg::st_r: begin
                    if (r_valid) begin
                        state <= mem_pkg::st_idle;
                        done_q <= 1'b1;
                        err_q <= (r.resp == mem_pkg::resp_decerr);
                    end
                end
                mem_pkg::st_aw: if (aw_ready) state <= mem_pkg::st_w;
                mem_pkg::st_w: if (w_ready) state <= mem_pkg::st_b;
                mem_pkg::st_b: begin
                    if (b_valid) begin
                        state <= mem_pkg::st_idle;
                        done_q <= 1'b1;
                        err_q <= (b.resp == mem_pkg::resp_decerr);
                    end
                end
                default: state <= mem_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::st_r && r_valid) begin
            rdata_q <= load_ext; // held until next load
        end
    end

    assign rdata = rdata_q;
    // no-access request finishes at once
    assign done = done_q | (start && state == mem_pkg::st_idle && !ren && !wen);
    assign err = err_q;

endmodule

`default_nettype wire

//--- design/mem_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module mem_xbar (
    input wire logic clk,
    input wire logic reset,
    input mem_pkg::ar_t ar,
    input wire logic ar_valid,
    output logic ar_ready,
    output mem_pkg::r_t r,
    output logic r_valid,
    input mem_pkg::ar_t aw,
    input wire logic aw_valid,
    output logic aw_ready,
    input mem_pkg::w_t w,
    input wire logic w_valid,
    output logic w_ready,
    output mem_pkg::b_t b,
    output logic b_valid,
    output mem_pkg::ar_t sram_ar,
    output logic sram_ar_valid,
    input wire logic sram_ar_ready,
    input mem_pkg::r_t sram_r,
    input wire logic sram_r_valid,
    output mem_pkg::ar_t sram_aw,
    output logic sram_aw_valid,
    input wire logic sram_aw_ready,
    output mem_pkg::w_t sram_w,
    output logic sram_w_valid,
    input wire logic sram_w_ready,
    input mem_pkg::b_t sram_b,
    input wire logic sram_b_valid,
    output mem_pkg::ar_t clint_ar,
    output logic clint_ar_valid,
    input wire logic clint_ar_ready,
    input mem_pkg::r_t clint_r,
    input wire logic clint_r_valid
);

    logic rd_sram;
    logic rd_clint;
    logic wr_sram;
    logic err_r_valid;
    logic err_b_valid;

    assign rd_sram = ar.addr >= mem_pkg::sram_base &&
                     ar.addr < mem_pkg::sram_base + 32'(mem_pkg::sram_words * 4);
    assign rd_clint = ar.addr >= mem_pkg::clint_base && ar.addr <= mem_pkg::clint_end;
    assign wr_sram = aw.addr >= mem_pkg::sram_base &&
                     aw.addr < mem_pkg::sram_base + 32'(mem_pkg::sram_words * 4);

    assign sram_ar = ar;
    assign sram_ar_valid = ar_valid & rd_sram;
    assign clint_ar = ar;
    assign clint_ar_valid = ar_valid & rd_clint;
    assign ar_ready = rd_sram ? sram_ar_ready : (rd_clint ? clint_ar_ready : 1'b1);

    assign r = rd_sram ? sram_r :
               (rd_clint ? clint_r : '{data: 32'h0, resp: mem_pkg::resp_decerr});
    assign r_valid = rd_sram ? sram_r_valid : (rd_clint ? clint_r_valid : err_r_valid);

    // clint window is read only
    assign sram_aw = aw;
    assign sram_aw_valid = aw_valid & wr_sram;
    assign sram_w = w;
    assign sram_w_valid = w_valid & wr_sram;
    assign aw_ready = wr_sram ? sram_aw_ready : 1'b1;
    assign w_ready = wr_sram ? sram_w_ready : 1'b1;
    assign b = wr_sram ? sram_b : '{resp: mem_pkg::resp_decerr};
    assign b_valid = wr_sram ? sram_b_valid : err_b_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            err_r_valid <= 1'b0;
            err_b_valid <= 1'b0;
        end else begin
            err_r_valid <= ar_valid && !rd_sram && !rd_clint; // answer next cycle
            err_b_valid <= w_valid && !wr_sram;
        end
    end

endmodule

`default_nettype wire

//--- design/clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint (
    input wire logic clk,
    input wire logic reset,
    input mem_pkg::ar_t ar,
    input wire logic ar_valid,
    output logic ar_ready,
    output mem_pkg::r_t r,
    output logic r_valid
);

    logic [63:0] mtime;
    logic [31:0] rdata_q;
    logic r_valid_q;

    assign ar_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime <= 64'h0;
            r_valid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            r_valid_q <= ar_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid) begin
            rdata_q <= ar.addr[2] ? mtime[63:32] : mtime[31:0]; // offset 4 is high word
        end
    end

    assign r = '{data: rdata_q, resp: mem_pkg::resp_okay};
    assign r_valid = r_valid_q;

endmodule

`default_nettype wire

//--- design/sram.sv
`timescale 1ns/1ps
`default_nettype none

module sram (
    input wire logic clk,
    input wire logic reset,
    input mem_pkg::ar_t ar,
    input wire logic ar_valid,
    output logic ar_ready,
    output mem_pkg::r_t r,
    output logic r_valid,
    input mem_pkg::ar_t aw,
    input wire logic aw_valid,
    output logic aw_ready,
    input mem_pkg::w_t w,
    input wire logic w_valid,
    output logic w_ready,
    output mem_pkg::b_t b,
    output logic b_valid
);

    logic [31:0] mem [mem_pkg::sram_words];
    logic [7:0] waddr_q;
    logic [31:0] rdata_q;
    logic r_valid_q;
    logic b_valid_q;

    assign ar_ready = 1'b1;
    assign aw_ready = 1'b1;
    assign w_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (aw_valid) begin
            waddr_q <= aw.addr[9:2]; // word index for the w beat
        end
        if (w_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[waddr_q][i*8 +: 8] <= w.data[i*8 +: 8];
                end
            end
        end
        if (ar_valid) begin
            rdata_q <= mem[ar.addr[9:2]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            r_valid_q <= ar_valid;
            b_valid_q <= w_valid;
        end
    end

    assign r = '{data: rdata_q, resp: mem_pkg::resp_okay};
    assign r_valid = r_valid_q;
    assign b = '{resp: mem_pkg::resp_okay};
    assign b_valid = b_valid_q;

endmodule

`default_nettype wire

//--- design/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic wen,
    input wire logic ren,
    input wire logic sign,
    input mem_pkg::mem_size_e size,
    input wire logic [31:0] addr,
    input wire logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic done,
    output logic err
);

    mem_pkg::ar_t ar, aw, sram_ar, sram_aw, clint_ar;
    mem_pkg::w_t w, sram_w;
    mem_pkg::r_t r, sram_r, clint_r;
    mem_pkg::b_t b, sram_b;
    logic ar_valid, ar_ready, r_valid, aw_valid, aw_ready, w_valid, w_ready, b_valid;
    logic sram_ar_valid, sram_ar_ready, sram_r_valid, sram_aw_valid, sram_aw_ready;
    logic sram_w_valid, sram_w_ready, sram_b_valid;
    logic clint_ar_valid, clint_ar_ready, clint_r_valid;

    lsu lsu_i (.*);

    mem_xbar xbar_i (.*);

    clint clint_i (
        .clk(clk), .reset(reset),
        .ar(clint_ar), .ar_valid(clint_ar_valid), .ar_ready(clint_ar_ready),
        .r(clint_r), .r_valid(clint_r_valid)
    );

    sram sram_i (
        .clk(clk), .reset(reset),
        .ar(sram_ar), .ar_valid(sram_ar_valid), .ar_ready(sram_ar_ready),
        .r(sram_r), .r_valid(sram_r_valid),
        .aw(sram_aw), .aw_valid(sram_aw_valid), .aw_ready(sram_aw_ready),
        .w(sram_w), .w_valid(sram_w_valid), .w_ready(sram_w_ready),
        .b(sram_b), .b_valid(sram_b_valid)
    );

endmodule

`default_nettype wire

//--- test/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    logic clk;
    logic reset;
    logic start;
    logic wen;
    logic ren;
    logic sign;
    mem_pkg::mem_size_e size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic done;
    logic err;

    logic [31:0] model [mem_pkg::sram_words]; // mirror of the sram
    logic [31:0] rng;
    int idx;
    int off;
    int waited;
    logic is_half;
    logic sgn;
    logic e;
    logic [31:0] data;
    logic [31:0] wd;
    logic [31:0] t0;
    logic [31:0] t1;
    mem_pkg::mem_size_e sz;

    mem_subsys dut_i (
        .clk(clk), .reset(reset), .start(start), .wen(wen), .ren(ren), .sign(sign),
        .size(size), .addr(addr), .wdata(wdata), .rdata(rdata), .done(done), .err(err)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] sram_addr(input int word, input int byte_off);
        return mem_pkg::sram_base + 32'(word * 4 + byte_off);
    endfunction

    // expected load result from the model word
    function automatic logic [31:0] extend_load(input logic [31:0] word, input int byte_off,
                                                 input logic half, input logic signed_ld);
        logic [31:0] s;
        s = word >> (byte_off * 8);
        if (half) begin
            return {{16{signed_ld & s[15]}}, s[15:0]};
        end
        return {{24{signed_ld & s[7]}}, s[7:0]};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_err(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after one
    task automatic issue_access(input logic w_en, input logic r_en, input logic signed_ld,
                                input mem_pkg::mem_size_e a_size, input logic [31:0] a,
                                input logic [31:0] d, output logic [31:0] rd,
                                output logic rd_err, output int cycles);
        logic got;
        got = 1'b0;
        cycles = 0;
        rd = 32'h0;
        rd_err = 1'b0;
        start = 1'b1;
        wen = w_en;
        ren = r_en;
        sign = signed_ld;
        size = a_size;
        addr = a;
        wdata = d;
        while (!got && cycles < 100) begin
            @(negedge clk);
            if (done) begin
                got = 1'b1;
                rd = rdata;
                rd_err = err;
            end else begin
                cycles++;
            end
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        if (!got) begin
            abort_run("timeout: done never came for the request");
        end
    endtask

    task automatic store(input mem_pkg::mem_size_e a_size, input logic [31:0] a,
                         input logic [31:0] d, output logic rd_err);
        logic [31:0] unused_rd;
        int cycles;
        issue_access(1'b1, 1'b0, 1'b0, a_size, a, d, unused_rd, rd_err, cycles);
    endtask

    task automatic load(input mem_pkg::mem_size_e a_size, input logic signed_ld,
                        input logic [31:0] a, output logic [31:0] rd, output logic rd_err);
        int cycles;
        issue_access(1'b0, 1'b1, signed_ld, a_size, a, 32'h0, rd, rd_err, cycles);
    endtask

    task automatic verify_all(input string name);
        logic [31:0] rd;
        logic rd_err;
        for (int i = 0; i < mem_pkg::sram_words; i++) begin
            load(mem_pkg::size_word, 1'b0, sram_addr(i, 0), rd, rd_err);
            check_data(name, model[i], rd);
            check_err(name, 1'b0, rd_err);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        wen = 1'b0;
        ren = 1'b0;
        sign = 1'b0;
        size = mem_pkg::size_none;
        addr = 32'h0;
        wdata = 32'h0;
        rng = 32'h252b;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < mem_pkg::sram_words; i++) begin
            rng = xorshift32(rng);
            model[i] = rng;
            store(mem_pkg::size_word, sram_addr(i, 0), rng, e);
            check_err("word store", 1'b0, e);
        end
        for (int n = 0; n < 256; n++) begin
            rng = xorshift32(rng);
            idx = int'(rng[7:0]);
            load(mem_pkg::size_word, 1'b0, sram_addr(idx, 0), data, e);
            check_data("word load", model[idx], data);
            check_err("word load", 1'b0, e);
        end

        for (int n = 0; n < 64; n++) begin
            rng = xorshift32(rng);
            idx = int'(rng[7:0]);
            is_half = rng[8];
            off = is_half ? int'({rng[9], 1'b0}) : int'(rng[10:9]);
            sz = is_half ? mem_pkg::size_half : mem_pkg::size_byte;
            rng = xorshift32(rng);
            wd = rng;
            store(sz, sram_addr(idx, off), wd, e);
            check_err("sub-word store", 1'b0, e);
            if (is_half) begin
                model[idx][off*8 +: 16] = wd[15:0];
            end else begin
                model[idx][off*8 +: 8] = wd[7:0];
            end
        end
        verify_all("sub-word readback");

        for (int n = 0; n < 64; n++) begin
            rng = xorshift32(rng);
            idx = int'(rng[7:0]);
            is_half = rng[8];
            off = is_half ? int'({rng[9], 1'b0}) : int'(rng[10:9]);
            sgn = rng[11];
            sz = is_half ? mem_pkg::size_half : mem_pkg::size_byte;
            load(sz, sgn, sram_addr(idx, off), data, e);
            check_data("load extension", extend_load(model[idx], off, is_half, sgn), data);
            check_err("load extension", 1'b0, e);
        end

        load(mem_pkg::size_word, 1'b0, mem_pkg::clint_base, t0, e);
        check_err("mtime first read", 1'b0, e);
        load(mem_pkg::size_word, 1'b0, mem_pkg::clint_base, t1, e);
        check_err("mtime second read", 1'b0, e);
        if (t1 <= t0) begin
            abort_run("mtime did not increase between two reads");
        end
        if (t0 == 32'h0) begin
            abort_run("mtime low word read back as zero");
        end
        load(mem_pkg::size_word, 1'b0, mem_pkg::clint_base + 32'h4, data, e);
        check_data("mtime high word", 32'h0, data);
        check_err("mtime high word", 1'b0, e);

        load(mem_pkg::size_word, 1'b0, 32'h1000_0000, data, e);
        check_err("unmapped load", 1'b1, e);
        rng = xorshift32(rng);
        store(mem_pkg::size_word, mem_pkg::clint_base, rng, e);
        check_err("clint store", 1'b1, e);
        rng = xorshift32(rng);
        store(mem_pkg::size_word, 32'h4000_0000, rng, e);
        check_err("unmapped store", 1'b1, e);
        rng = xorshift32(rng);
        store(mem_pkg::size_word, sram_addr(mem_pkg::sram_words, 0), rng, e); // just past sram
        check_err("store past sram", 1'b1, e);
        verify_all("sram after decode errors");

        issue_access(1'b0, 1'b0, 1'b0, mem_pkg::size_none, 32'h0, 32'h0, data, e, waited);
        if (waited != 0) begin
            abort_run("no-access request did not finish in the start cycle");
        end
        check_err("no-access request", 1'b0, e);
        rng = xorshift32(rng);
        idx = int'(rng[7:0]);
        load(mem_pkg::size_word, 1'b0, sram_addr(idx, 0), data, e);
        check_data("load after no-access", model[idx], data);
        check_err("load after no-access", 1'b0, e);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/mem_pkg.sv
design/lsu.sv
design/mem_xbar.sv
design/clint.sv
design/sram.sv
design/mem_subsys.sv
test/mem_subsys_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := mem_subsys_tb
FILELIST  := verilog.f
LOG       := sim.log
FAIL_MSG  := \*\*\* FAILED \*\*\*

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
